//--- boot_pkg.sv
// ################################################
// boot package
// secure memory geometry, lifecycle states and
// the boot sequence states
// ################################################

package boot_pkg;

    // secure memory
    localparam int mem_width      = 256;
    localparam int mem_depth      = 16;
    localparam int mem_addr_width = $clog2(mem_depth);

    localparam logic [mem_addr_width-1:0] chip_id_addr = '0;

    // lifecycle identifiers share the memory word width
    localparam int lc_id_width = mem_width;

    typedef enum logic [2:0] {
        lc_raw  = 3'd0,
        lc_test = 3'd1,
        lc_dev  = 3'd2,
        lc_prod = 3'd3
    } lc_state_t;

    typedef enum logic [3:0] {
        st_wake       = 4'd0,
        st_collect    = 4'd1,
        st_write_id   = 4'd2,
        st_read_id    = 4'd3,
        st_compare    = 4'd4,
        st_lc_request = 4'd5,
        st_lc_wait    = 4'd6,
        st_lc_poll    = 4'd7
    } boot_state_t;

endpackage

//--- ipid_pkg.sv
// ################################################
// ip identification bus package
// word framing, identifier geometry and the
// receiver states
// ################################################

package ipid_pkg;

    localparam int ipid_count      = 4;
    localparam int ipid_word_width = 16;
    localparam int ipid_words      = 16;
    localparam int ipid_width      = ipid_words * ipid_word_width;
    localparam int ipid_sel_width  = $clog2(ipid_count);
    localparam int ipid_cnt_width  = $clog2(ipid_words);

    localparam logic [ipid_word_width-1:0] ipid_start_marker = 16'h7A7A;
    localparam logic [ipid_word_width-1:0] ipid_stop_marker  = 16'hB9B9;

    typedef enum logic [1:0] {
        rx_idle       = 2'd0,
        rx_wait_start = 2'd1,
        rx_data       = 2'd2,
        rx_wait_stop  = 2'd3
    } rx_state_t;

endpackage

//--- ipid_word_if.sv
// ################################################
// ip identifier word channel
// carries framed words from the bus receiver to
// the per-ip identifier slots
// ################################################

`timescale 1ns/100ps

interface ipid_word_if;
    import ipid_pkg::*;

    logic                       word_valid;
    logic [ipid_word_width-1:0] word;
    logic [ipid_sel_width-1:0]  slot_sel;
    logic                       restart;
    logic                       commit;

    modport rx (
        output word_valid, word, slot_sel, restart, commit
    );

    modport slot (
        input word_valid, word, slot_sel, restart, commit
    );

endinterface

//--- ipid_receiver.sv
// ################################################
// ip identification bus receiver
// wakes the bus, triggers each ip in turn and
// frames the returned identifier packets
// bad packets restart the slot and re-trigger
// ################################################

`timescale 1ns/100ps

module ipid_receiver (
    input  logic                                 clk,
    input  logic                                 fuse,
    input  logic                                 collect_start,
    input  logic                                 bus_wake_ack,
    input  logic [ipid_pkg::ipid_word_width-1:0] bus_word,
    input  logic                                 bus_word_valid,
    output logic                                 bus_wake,
    output logic                                 ipid_trigger,
    output logic [ipid_pkg::ipid_sel_width-1:0]  ipid_sel,
    ipid_word_if.rx                              words
);
    import ipid_pkg::*;

    rx_state_t                 state;
    logic [ipid_cnt_width-1:0] word_cnt;
    logic                      waking;
    logic                      last_ip;

    assign words.slot_sel = ipid_sel;
    assign last_ip        = (ipid_sel == ipid_sel_width'(ipid_count - 1));

    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            state            <= rx_idle;
            word_cnt         <= '0;
            waking           <= 1'b0;
            ipid_sel         <= '0;
            bus_wake         <= 1'b0;
            ipid_trigger     <= 1'b0;
            words.word_valid <= 1'b0;
            words.restart    <= 1'b0;
            words.commit     <= 1'b0;
        end else begin
            bus_wake         <= 1'b0;
            ipid_trigger     <= 1'b0;
            words.word_valid <= 1'b0;
            words.restart    <= 1'b0;
            words.commit     <= 1'b0;
            case (state)
                rx_idle: begin
                    if (collect_start) begin
                        bus_wake <= 1'b1;
                        waking   <= 1'b1;
                    end else if (waking && bus_wake_ack) begin
                        waking       <= 1'b0;
                        ipid_sel     <= '0;
                        ipid_trigger <= 1'b1;
                        state        <= rx_wait_start;
                    end else if (words.commit && !last_ip) begin
                        // next ip once the previous one is stored
                        ipid_sel     <= ipid_sel + 1'b1;
                        ipid_trigger <= 1'b1;
                        state        <= rx_wait_start;
                    end
                end
                rx_wait_start: begin
                    if (bus_word_valid && bus_word == ipid_start_marker) begin
                        word_cnt <= '0;
                        state    <= rx_data;
                    end
                end
                rx_data: begin
                    if (bus_word_valid) begin
                        if (bus_word == ipid_stop_marker) begin
                            // stop came too early
                            words.restart <= 1'b1;
                            ipid_trigger  <= 1'b1;
                            state         <= rx_wait_start;
                        end else begin
                            words.word_valid <= 1'b1;
                            word_cnt         <= word_cnt + 1'b1;
                            if (word_cnt == ipid_cnt_width'(ipid_words - 1)) begin
                                state <= rx_wait_stop;
                            end
                        end
                    end
                end
                rx_wait_stop: begin
                    if (bus_word_valid) begin
                        if (bus_word == ipid_stop_marker) begin
                            words.commit <= 1'b1;
                            state        <= rx_idle;
                        end else begin
                            words.restart <= 1'b1;
                            ipid_trigger  <= 1'b1;
                            state         <= rx_wait_start;
                        end
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == rx_data && bus_word_valid) begin
            words.word <= bus_word;
        end
    end

endmodule

//--- ipid_slot.sv
// ################################################
// ip identifier slot
// shifts in the words for one ip and flags the
// identifier complete on commit
// ################################################

`timescale 1ns/100ps

module ipid_slot #(
    parameter int slot_index = 0
) (
    input  logic                            clk,
    input  logic                            fuse,
    ipid_word_if.slot                       words,
    output logic [ipid_pkg::ipid_width-1:0] ipid,
    output logic                            full
);
    import ipid_pkg::*;

    logic selected;

    assign selected = (words.slot_sel == ipid_sel_width'(slot_index));

    // first word ends up in the low bits
    always_ff @(posedge clk) begin
        if (selected) begin
            if (words.restart) begin
                ipid <= '0;
            end else if (words.word_valid) begin
                ipid <= {words.word, ipid[ipid_width-1:ipid_word_width]};
            end
        end
    end

    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            full <= 1'b0;
        end else if (selected) begin
            if (words.restart) begin
                full <= 1'b0;
            end else if (words.commit) begin
                full <= 1'b1;
            end
        end
    end

endmodule

//--- chip_id_combiner.sv
// ################################################
// chip identifier combiner
// xor fold of both puf signatures and every ip
// identifier, taken once all slots are full
// ################################################

`timescale 1ns/100ps

module chip_id_combiner (
    input  logic                                                 clk,
    input  logic                                                 fuse,
    input  logic [boot_pkg::mem_width-1:0]                       puf_a,
    input  logic [boot_pkg::mem_width-1:0]                       puf_b,
    input  logic [ipid_pkg::ipid_count*ipid_pkg::ipid_width-1:0] ipid_bus,
    input  logic [ipid_pkg::ipid_count-1:0]                      full_bus,
    output logic [boot_pkg::mem_width-1:0]                       chip_id,
    output logic                                                 chip_id_valid
);
    import boot_pkg::*;
    import ipid_pkg::*;

    logic [mem_width-1:0] fold;
    logic                 capture;

    assign capture = (&full_bus) && !chip_id_valid;

    always_comb begin
        fold = puf_a ^ puf_b;
        for (int i = 0; i < ipid_count; i++) begin
            fold = fold ^ ipid_bus[i*ipid_width +: ipid_width];
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            chip_id <= fold;
        end
    end

    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            chip_id_valid <= 1'b0;
        end else if (capture) begin
            chip_id_valid <= 1'b1;
        end
    end

endmodule

//--- boot_sequencer.sv
// ################################################
// boot sequencer
// collects the chip identifier, then provisions
// it in a raw part or challenges it otherwise,
// and finally forwards lifecycle transitions
// ################################################

`timescale 1ns/100ps

module boot_sequencer (
    input  logic                                clk,
    input  logic                                fuse,
    input  boot_pkg::lc_state_t                 lc_state,
    input  logic [boot_pkg::mem_width-1:0]      chip_id,
    input  logic                                chip_id_valid,
    input  logic [boot_pkg::mem_width-1:0]      rd_data,
    input  logic                                rd_data_valid,
    input  logic                                lc_done,
    input  logic                                lc_success,
    input  logic                                lc_request_in,
    input  logic [boot_pkg::lc_id_width-1:0]    lc_request_id,
    output logic                                collect_start,
    output logic                                rd_en,
    output logic                                wr_en,
    output logic [boot_pkg::mem_addr_width-1:0] mem_addr,
    output logic [boot_pkg::mem_width-1:0]      wr_data,
    output logic                                lc_transition_request,
    output logic [boot_pkg::lc_id_width-1:0]    lc_identifier,
    output logic                                boot_done,
    output logic                                chip_id_match
);
    import boot_pkg::*;

    boot_state_t          state;
    logic [mem_width-1:0] rd_q;

    // only the chip identifier word is ever accessed
    assign mem_addr = chip_id_addr;

    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            state                 <= st_wake;
            collect_start         <= 1'b0;
            rd_en                 <= 1'b0;
            wr_en                 <= 1'b0;
            lc_transition_request <= 1'b0;
            boot_done             <= 1'b0;
            chip_id_match         <= 1'b0;
        end else begin
            collect_start         <= 1'b0;
            wr_en                 <= 1'b0;
            lc_transition_request <= 1'b0;
            case (state)
                st_wake: begin
                    collect_start <= 1'b1;
                    state         <= st_collect;
                end
                st_collect: begin
                    if (chip_id_valid) begin
                        if (lc_state == lc_raw) begin
                            wr_en <= 1'b1;
                            state <= st_write_id;
                        end else begin
                            rd_en <= 1'b1;
                            state <= st_read_id;
                        end
                    end
                end
                st_write_id: state <= st_lc_request;
                st_read_id: begin
                    // hold the read until memory answers
                    if (rd_data_valid) begin
                        rd_en <= 1'b0;
                        state <= st_compare;
                    end
                end
                st_compare: begin
                    chip_id_match <= (rd_q == chip_id);
                    boot_done     <= 1'b1;
                    state         <= st_lc_poll;
                end
                st_lc_request: begin
                    lc_transition_request <= 1'b1;
                    state                 <= st_lc_wait;
                end
                st_lc_wait: begin
                    if (lc_done) begin
                        // a refused provisioning transition is retried
                        if (!lc_success && !boot_done) begin
                            state <= st_lc_request;
                        end else begin
                            boot_done <= 1'b1;
                            state     <= st_lc_poll;
                        end
                    end
                end
                st_lc_poll: begin
                    if (lc_request_in) begin
                        state <= st_lc_request;
                    end
                end
                default: state <= st_wake;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_read_id && rd_data_valid) begin
            rd_q <= rd_data;
        end
        if (state == st_collect && chip_id_valid) begin
            wr_data <= chip_id;
        end
        // raw to test uses identifier zero
        if (state == st_write_id) begin
            lc_identifier <= '0;
        end else if (state == st_lc_poll && lc_request_in) begin
            lc_identifier <= lc_request_id;
        end
    end

endmodule

//--- secure_boot_top.sv
// ################################################
// secure boot top level
// bus receiver, identifier slots, chip identifier
// combiner and boot sequencer
// ################################################

`timescale 1ns/100ps

module secure_boot_top (
    input  logic                                 clk,
    input  logic                                 fuse,
    input  boot_pkg::lc_state_t                  lc_state,
    input  logic [boot_pkg::mem_width-1:0]       puf_a,
    input  logic [boot_pkg::mem_width-1:0]       puf_b,
    input  logic                                 bus_wake_ack,
    input  logic [ipid_pkg::ipid_word_width-1:0] bus_word,
    input  logic                                 bus_word_valid,
    input  logic [boot_pkg::mem_width-1:0]       rd_data,
    input  logic                                 rd_data_valid,
    input  logic                                 lc_done,
    input  logic                                 lc_success,
    input  logic                                 lc_request_in,
    input  logic [boot_pkg::lc_id_width-1:0]     lc_request_id,
    output logic                                 bus_wake,
    output logic                                 ipid_trigger,
    output logic [ipid_pkg::ipid_sel_width-1:0]  ipid_sel,
    output logic                                 rd_en,
    output logic                                 wr_en,
    output logic [boot_pkg::mem_addr_width-1:0]  mem_addr,
    output logic [boot_pkg::mem_width-1:0]       wr_data,
    output logic                                 lc_transition_request,
    output logic [boot_pkg::lc_id_width-1:0]     lc_identifier,
    output logic                                 boot_done,
    output logic                                 chip_id_match
);
    import boot_pkg::*;
    import ipid_pkg::*;

    logic                             collect_start;
    logic [mem_width-1:0]             chip_id;
    logic                             chip_id_valid;
    logic [ipid_count*ipid_width-1:0] ipid_bus;
    logic [ipid_count-1:0]            full_bus;

    ipid_word_if word_if ();

    ipid_receiver rx0 (
        .clk            (clk),
        .fuse           (fuse),
        .collect_start  (collect_start),
        .bus_wake_ack   (bus_wake_ack),
        .bus_word       (bus_word),
        .bus_word_valid (bus_word_valid),
        .bus_wake       (bus_wake),
        .ipid_trigger   (ipid_trigger),
        .ipid_sel       (ipid_sel),
        .words          (word_if.rx)
    );

    for (genvar i = 0; i < ipid_count; i++) begin : g_slot
        ipid_slot #(
            .slot_index (i)
        ) slot0 (
            .clk   (clk),
            .fuse  (fuse),
            .words (word_if.slot),
            .ipid  (ipid_bus[i*ipid_width +: ipid_width]),
            .full  (full_bus[i])
        );
    end

    chip_id_combiner comb0 (
        .clk           (clk),
        .fuse          (fuse),
        .puf_a         (puf_a),
        .puf_b         (puf_b),
        .ipid_bus      (ipid_bus),
        .full_bus      (full_bus),
        .chip_id       (chip_id),
        .chip_id_valid (chip_id_valid)
    );

    boot_sequencer seq0 (
        .clk                   (clk),
        .fuse                  (fuse),
        .lc_state              (lc_state),
        .chip_id               (chip_id),
        .chip_id_valid         (chip_id_valid),
        .rd_data               (rd_data),
        .rd_data_valid         (rd_data_valid),
        .lc_done               (lc_done),
        .lc_success            (lc_success),
        .lc_request_in         (lc_request_in),
        .lc_request_id         (lc_request_id),
        .collect_start         (collect_start),
        .rd_en                 (rd_en),
        .wr_en                 (wr_en),
        .mem_addr              (mem_addr),
        .wr_data               (wr_data),
        .lc_transition_request (lc_transition_request),
        .lc_identifier         (lc_identifier),
        .boot_done             (boot_done),
        .chip_id_match         (chip_id_match)
    );

endmodule

//--- secure_boot_assertions.sv
// ################################################
// secure boot handshake checks
// memory strobes, trigger pulse width and read
// request hold, bound to the top level
// ################################################

`timescale 1ns/100ps

module secure_boot_assertions (
    input logic clk,
    input logic fuse,
    input logic wr_en,
    input logic rd_en,
    input logic rd_data_valid,
    input logic ipid_trigger
);

    int fail_count = 0;

    no_rd_wr_overlap: assert property (
        @(posedge clk) disable iff (!fuse) !(wr_en && rd_en)
    ) else begin
        $error("rd_en and wr_en high together");
        fail_count++;
    end

    // trigger is a single cycle pulse
    trigger_pulse: assert property (
        @(posedge clk) disable iff (!fuse) ipid_trigger |=> !ipid_trigger
    ) else begin
        $error("ipid_trigger high for more than one cycle");
        fail_count++;
    end

    rd_en_held: assert property (
        @(posedge clk) disable iff (!fuse) rd_en && !rd_data_valid |=> rd_en
    ) else begin
        $error("rd_en dropped before rd_data_valid");
        fail_count++;
    end

endmodule

bind secure_boot_top secure_boot_assertions sva0 (
    .clk           (clk),
    .fuse          (fuse),
    .wr_en         (wr_en),
    .rd_en         (rd_en),
    .rd_data_valid (rd_data_valid),
    .ipid_trigger  (ipid_trigger)
);

//--- tb_secure_boot.sv
// ################################################
// secure boot testbench
// lfsr driven bus, memory and lifecycle models,
// checked against an xor fold reference model
// ################################################

`timescale 1ns/100ps

module tb_secure_boot;
    import boot_pkg::*;
    import ipid_pkg::*;

    // four packets plus one resend of 19 words with gaps and handshakes over three boots
    localparam int max_cycles = 4 * 3 * (8 + 5 * 19 * 2 + 60);

    logic                       clk;
    logic                       fuse;
    lc_state_t                  lc_state;
    logic [mem_width-1:0]       puf_a;
    logic [mem_width-1:0]       puf_b;
    logic                       bus_wake_ack;
    logic [ipid_word_width-1:0] bus_word;
    logic                       bus_word_valid;
    logic [mem_width-1:0]       rd_data;
    logic                       rd_data_valid;
    logic                       lc_done;
    logic                       lc_success;
    logic                       lc_request_in;
    logic [lc_id_width-1:0]     lc_request_id;
    logic                       bus_wake;
    logic                       ipid_trigger;
    logic [ipid_sel_width-1:0]  ipid_sel;
    logic                       rd_en;
    logic                       wr_en;
    logic [mem_addr_width-1:0]  mem_addr;
    logic [mem_width-1:0]       wr_data;
    logic                       lc_transition_request;
    logic [lc_id_width-1:0]     lc_identifier;
    logic                       boot_done;
    logic                       chip_id_match;

    logic [31:0]            lfsr_q;
    logic [ipid_width-1:0]  ids [ipid_count];
    logic [mem_width-1:0]   model_id;
    logic [mem_width-1:0]   mem [mem_depth];
    logic [lc_id_width-1:0] last_lc_id;
    int                     write_count;
    int                     lc_req_count;
    int                     lc_done_count;
    int                     trig_count [ipid_count];
    int                     bad_ip;
    bit                     bad_pending;
    bit                     seen_wake;

    secure_boot_top dut0 (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Test failures found");
        $fatal(1, "timeout, tests did not finish within %0d cycles", max_cycles);
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [255:0] rand_wide();
        logic [255:0] r;
        for (int i = 0; i < 8; i++) begin
            r[i*32 +: 32] = rand_bits(32);
        end
        return r;
    endfunction

    task automatic check(input logic [255:0] got, input logic [255:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s: got %0h, expected %0h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "value mismatch in %s", what);
        end
    endtask

    // fresh puf values and ip identifiers with the expected chip identifier
    task automatic new_identity();
        logic [15:0] w;
        puf_a    = rand_wide();
        puf_b    = rand_wide();
        model_id = puf_a ^ puf_b;
        for (int ip = 0; ip < ipid_count; ip++) begin
            for (int k = 0; k < ipid_words; k++) begin
                w = 16'(rand_bits(16));
                // a data word equal to the stop marker would end the packet
                if (w == ipid_stop_marker) begin
                    w = ~w;
                end
                ids[ip][k*16 +: 16] = w;
            end
            model_id = model_id ^ ids[ip];
        end
    endtask

    task automatic put_word(input logic [15:0] w);
        while (rand_bits(2) == 0) begin
            bus_word_valid = 1'b0;
            @(negedge clk);
        end
        bus_word       = w;
        bus_word_valid = 1'b1;
        @(negedge clk);
    endtask

    task automatic send_packet(input int ip, input bit early);
        // filler ahead of the start marker
        put_word(16'h0f0f);
        put_word(ipid_start_marker);
        for (int k = 0; k < (early ? 5 : ipid_words); k++) begin
            put_word(ids[ip][k*16 +: 16]);
        end
        put_word(ipid_stop_marker);
        bus_word_valid = 1'b0;
    endtask

    task automatic do_boot();
        fuse         = 1'b0;
        bus_wake_ack = 1'b0;
        seen_wake    = 1'b0;
        for (int ip = 0; ip < ipid_count; ip++) begin
            trig_count[ip] = 0;
        end
        repeat (8) @(negedge clk);
        check(256'({bus_wake, ipid_trigger, rd_en, wr_en, lc_transition_request,
                    boot_done, chip_id_match}), 0, "control outputs in reset");
        fuse = 1'b1;
        while (boot_done !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    initial begin : bus_model
        bit early;
        forever begin
            if (ipid_trigger === 1'b1) begin
                check(256'(seen_wake), 1, "bus wake ahead of the first trigger");
                trig_count[ipid_sel]++;
                early = bad_pending && (int'(ipid_sel) == bad_ip);
                if (early) begin
                    bad_pending = 1'b0;
                end
                send_packet(int'(ipid_sel), early);
            end else begin
                if (bus_wake === 1'b1) begin
                    seen_wake    = 1'b1;
                    bus_wake_ack = 1'b1;
                end
                @(negedge clk);
            end
        end
    end

    initial begin : mem_model
        forever begin
            @(negedge clk);
            if (wr_en === 1'b1) begin
                write_count++;
                check(256'(mem_addr), 256'(chip_id_addr), "write address");
                check(wr_data, model_id, "provisioned chip identifier");
                mem[mem_addr] = wr_data;
            end
            if (rd_en === 1'b1) begin
                repeat (rand_bits(3)) @(negedge clk);
                rd_data       = mem[mem_addr];
                rd_data_valid = 1'b1;
                @(negedge clk);
                rd_data_valid = 1'b0;
            end
        end
    end

    initial begin : lc_model
        forever begin
            @(negedge clk);
            if (lc_transition_request === 1'b1) begin
                lc_req_count++;
                last_lc_id = lc_identifier;
                repeat (rand_bits(3)) @(negedge clk);
                if (lc_done_count == 0) begin
                    check(256'(boot_done), 0, "boot_done ahead of lc_done");
                end
                lc_done    = 1'b1;
                lc_success = 1'b1;
                @(negedge clk);
                lc_done    = 1'b0;
                lc_success = 1'b0;
                lc_done_count++;
                check(256'(boot_done), 1, "boot_done after lc_done");
            end
        end
    end

    initial begin : main
        logic [lc_id_width-1:0] req_id;
        lfsr_q         = 32'hc1ee_92a5;
        fuse           = 1'b0;
        lc_state       = lc_raw;
        puf_a          = '0;
        puf_b          = '0;
        bus_wake_ack   = 1'b0;
        bus_word       = '0;
        bus_word_valid = 1'b0;
        rd_data        = '0;
        rd_data_valid  = 1'b0;
        lc_done        = 1'b0;
        lc_success     = 1'b0;
        lc_request_in  = 1'b0;
        lc_request_id  = '0;
        write_count    = 0;
        lc_req_count   = 0;
        lc_done_count  = 0;
        bad_ip         = 0;
        bad_pending    = 1'b0;
        seen_wake      = 1'b0;
        for (int a = 0; a < mem_depth; a++) begin
            mem[a] = {64{4'(a)}};
        end

        // raw part where one ip first answers with a short packet
        new_identity();
        bad_ip      = int'(rand_bits(2));
        bad_pending = 1'b1;
        lc_state    = lc_raw;
        do_boot();
        check(256'(write_count), 1, "writes during provisioning");
        check(256'(lc_req_count), 1, "lifecycle requests during provisioning");
        check(last_lc_id, 0, "provisioning lifecycle identifier");
        for (int ip = 0; ip < ipid_count; ip++) begin
            check(256'(trig_count[ip]), (ip == bad_ip) ? 2 : 1, "triggers per ip");
        end

        // external request forwarded from the poll state
        req_id        = rand_wide();
        lc_request_id = req_id;
        lc_request_in = 1'b1;
        @(negedge clk);
        lc_request_in = 1'b0;
        while (lc_done_count < 2) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);
        check(256'(lc_req_count), 2, "forwarded lifecycle requests");
        check(last_lc_id, req_id, "forwarded lifecycle identifier");

        // challenge against the stored identifier
        new_identity();
        mem[chip_id_addr] = model_id;
        lc_state          = lc_dev;
        do_boot();
        check(256'(chip_id_match), 1, "match with stored identifier");

        new_identity();
        mem[chip_id_addr] = model_id ^ (256'd1 << rand_bits(8));
        lc_state          = lc_prod;
        do_boot();
        check(256'(chip_id_match), 0, "match with one flipped bit");
        check(256'(write_count), 1, "writes after challenge boots");

        if (dut0.sva0.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "bound handshake checker reported %0d failures", dut0.sva0.fail_count);
        end
    end

endmodule

//--- build.f
boot_pkg.sv
ipid_pkg.sv
ipid_word_if.sv
ipid_receiver.sv
ipid_slot.sv
chip_id_combiner.sv
boot_sequencer.sv
secure_boot_top.sv
secure_boot_assertions.sv
tb_secure_boot.sv
